//--- Makefile
# Verilator build and run for the debug privilege block

VERILATOR ?= verilator
SIM_TOP   ?= priv_debug_tb
FILELIST  ?= priv_debug_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/csr_access_unit.sv
`default_nettype none
`include "priv_debug_settings.svh"

module csr_access_unit import priv_debug_pkg::*; (
    input  logic               csr_req,
    input  logic [11:0]        csr_addr,
    input  csr_op_t            csr_op,
    input  logic [`DATA_W-1:0] csr_wdata,
    input  logic [`DATA_W-1:0] csr_rd_data,
    input  logic               halted,
    output logic               csr_ack,
    output logic               csr_invalid,
    output logic [`DATA_W-1:0] csr_rdata,
    output logic               csr_wr,
    output logic [1:0]         csr_sel,
    output logic [`DATA_W-1:0] csr_wr_data
);

    logic addr_hit;
    logic access_ok;

    // address decode into a register index
    always_comb begin
        addr_hit = 1'b1;
        csr_sel  = 2'd0;
        case (csr_addr)
            `CSR_DCSR:      csr_sel = 2'd0;
            `CSR_DPC:       csr_sel = 2'd1;
            `CSR_DSCRATCH0: csr_sel = 2'd2;
            `CSR_DSCRATCH1: csr_sel = 2'd3;
            default:        addr_hit = 1'b0;
        endcase
    end

    // debug csrs are only reachable from debug mode
    assign access_ok = csr_req && addr_hit && halted;

    assign csr_ack     = csr_req && addr_hit;
    assign csr_invalid = csr_req && !access_ok;
    assign csr_rdata   = addr_hit ? csr_rd_data : '0;

    // read-modify-write on the old value
    always_comb begin
        case (csr_op)
            CSR_WRITE: csr_wr_data = csr_wdata;
            CSR_SET:   csr_wr_data = csr_rd_data | csr_wdata;
            CSR_CLEAR: csr_wr_data = csr_rd_data & ~csr_wdata;
            default:   csr_wr_data = csr_rd_data;
        endcase
    end

    assign csr_wr = access_ok && (csr_op != CSR_READ);

endmodule

`default_nettype wire

//--- hw/debug_csr_file.sv
`default_nettype none
`include "priv_debug_settings.svh"

module debug_csr_file import priv_debug_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               csr_wr,
    input  logic [1:0]         csr_sel,
    input  logic [`DATA_W-1:0] csr_wr_data,
    input  logic               enter_debug,
    input  debug_cause_t       enter_cause,
    input  logic [`DATA_W-1:0] enter_pc,
    input  priv_level_t        enter_prv,
    output logic [`DATA_W-1:0] csr_rd_data,
    output logic [`DATA_W-1:0] dpc,
    output logic               dcsr_ebreakm,
    output logic               dcsr_ebreaku,
    output logic               dcsr_step,
    output priv_level_t        dcsr_prv
);

    localparam logic [1:0] SEL_DCSR      = 2'd0;
    localparam logic [1:0] SEL_DPC       = 2'd1;
    localparam logic [1:0] SEL_DSCRATCH0 = 2'd2;
    localparam logic [1:0] SEL_DSCRATCH1 = 2'd3;

    debug_cause_t       dcsr_cause;
    logic [`DATA_W-1:0] dcsr_value;
    logic [`DATA_W-1:0] dscratch0;
    logic [`DATA_W-1:0] dscratch1;
    priv_level_t        wr_prv;
    logic               wr_prv_legal;

    // only the four writable fields are stored, the rest is rebuilt on read
    always_comb begin
        dcsr_value = '0;
        dcsr_value[`DATA_W-1 -: 4] = `DCSR_XDEBUGVER;
        dcsr_value[`DCSR_EBREAKM_BIT] = dcsr_ebreakm;
        dcsr_value[`DCSR_EBREAKU_BIT] = dcsr_ebreaku;
        dcsr_value[`DCSR_CAUSE_LSB +: 3] = dcsr_cause;
        dcsr_value[`DCSR_STEP_BIT] = dcsr_step;
        dcsr_value[`DCSR_PRV_LSB +: 2] = dcsr_prv;
    end

    // prv is WARL, S and reserved are not supported
    assign wr_prv       = priv_level_t'(csr_wr_data[`DCSR_PRV_LSB +: 2]);
    assign wr_prv_legal = (wr_prv == PRIV_U) || (wr_prv == PRIV_M);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr_ebreakm <= 1'b0;
            dcsr_ebreaku <= 1'b0;
            dcsr_step    <= 1'b0;
            dcsr_cause   <= CAUSE_NONE;
            dcsr_prv     <= PRIV_M;
            dpc          <= '0;
            dscratch0    <= '0;
            dscratch1    <= '0;
        end else begin
            if (csr_wr) begin
                case (csr_sel)
                    SEL_DCSR: begin
                        dcsr_ebreakm <= csr_wr_data[`DCSR_EBREAKM_BIT];
                        dcsr_ebreaku <= csr_wr_data[`DCSR_EBREAKU_BIT];
                        dcsr_step    <= csr_wr_data[`DCSR_STEP_BIT];
                        if (wr_prv_legal) begin
                            dcsr_prv <= wr_prv;
                        end
                    end
                    SEL_DPC:       dpc <= {csr_wr_data[`DATA_W-1:1], 1'b0};
                    SEL_DSCRATCH0: dscratch0 <= csr_wr_data;
                    SEL_DSCRATCH1: dscratch1 <= csr_wr_data;
                    default: ;
                endcase
            end
            // entry snapshot, never coincides with a csr write
            if (enter_debug) begin
                dpc        <= {enter_pc[`DATA_W-1:1], 1'b0};
                dcsr_cause <= enter_cause;
                dcsr_prv   <= enter_prv;
            end
        end
    end

    // old value of the selected register
    always_comb begin
        case (csr_sel)
            SEL_DCSR:      csr_rd_data = dcsr_value;
            SEL_DPC:       csr_rd_data = dpc;
            SEL_DSCRATCH0: csr_rd_data = dscratch0;
            SEL_DSCRATCH1: csr_rd_data = dscratch1;
            default:       csr_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/debug_entry_ctrl.sv
`default_nettype none
`include "priv_debug_settings.svh"

module debug_entry_ctrl import priv_debug_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               haltreq,
    input  logic               ebreak,
    input  logic               retire,
    input  logic               dret,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] next_pc,
    input  logic               dcsr_ebreakm,
    input  logic               dcsr_ebreaku,
    input  logic               dcsr_step,
    input  priv_level_t        dcsr_prv,
    input  logic [`DATA_W-1:0] dpc,
    output logic               halted,
    output priv_level_t        priv,
    output logic               resume,
    output logic [`DATA_W-1:0] resume_pc,
    output logic               breakpoint_trap,
    output logic               enter_debug,
    output debug_cause_t       enter_cause,
    output logic [`DATA_W-1:0] enter_pc,
    output priv_level_t        enter_prv
);

    hart_state_t state;
    hart_state_t state_nxt;
    logic        running;
    logic        ebreak_en;
    logic        do_dret;

    assign running = (state == RUNNING);

    // ebreak enable for the current level
    assign ebreak_en = (priv == PRIV_M) ? dcsr_ebreakm : dcsr_ebreaku;

    // halt cause by priority: haltreq, ebreak, step
    always_comb begin
        enter_cause = CAUSE_NONE;
        if (haltreq) begin
            enter_cause = CAUSE_HALTREQ;
        end else if (ebreak && ebreak_en) begin
            enter_cause = CAUSE_EBREAK;
        end else if (retire && dcsr_step) begin
            enter_cause = CAUSE_STEP;
        end
    end

    assign enter_debug = running && (enter_cause != CAUSE_NONE);
    // a step halts after the instruction, so resume at the next one
    assign enter_pc    = (enter_cause == CAUSE_STEP) ? next_pc : pc;
    assign enter_prv   = priv;

    // ebreak without the debug enable goes to the normal trap path
    assign breakpoint_trap = running && ebreak && !ebreak_en;

    assign do_dret = (state == HALTED) && dret;

    always_comb begin
        state_nxt = state;
        case (state)
            RUNNING: begin
                if (enter_debug) begin
                    state_nxt = HALTED;
                end
            end
            HALTED: begin
                if (dret) begin
                    state_nxt = RUNNING;
                end
            end
            default: state_nxt = RUNNING;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= RUNNING;
            priv   <= PRIV_M;
            resume <= 1'b0;
        end else begin
            state  <= state_nxt;
            resume <= do_dret;
            // level comes back from dcsr.prv as the debugger left it
            if (do_dret) begin
                priv <= dcsr_prv;
            end
        end
    end

    assign halted    = (state == HALTED);
    assign resume_pc = dpc;

endmodule

`default_nettype wire

//--- hw/priv_debug_pkg.sv
`default_nettype none

package priv_debug_pkg;

    // privilege levels as encoded in dcsr.prv
    // only U and M are implemented
    typedef enum logic [1:0] {
        PRIV_U    = 2'd0,
        PRIV_S    = 2'd1,
        PRIV_RSVD = 2'd2,
        PRIV_M    = 2'd3
    } priv_level_t;

    // csr instruction flavours
    typedef enum logic [1:0] {
        CSR_READ  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

    // dcsr.cause encodings
    // 2 (trigger) and 5 (resethaltreq) are not produced here
    typedef enum logic [2:0] {
        CAUSE_NONE    = 3'd0,
        CAUSE_EBREAK  = 3'd1,
        CAUSE_HALTREQ = 3'd3,
        CAUSE_STEP    = 3'd4
    } debug_cause_t;

    // hart run state as seen by the debugger
    typedef enum logic {
        RUNNING = 1'b0,
        HALTED  = 1'b1
    } hart_state_t;

endpackage

`default_nettype wire

//--- hw/priv_debug_top.sv
`default_nettype none
`include "priv_debug_settings.svh"

module priv_debug_top import priv_debug_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               csr_req,
    input  logic [11:0]        csr_addr,
    input  csr_op_t            csr_op,
    input  logic [`DATA_W-1:0] csr_wdata,
    input  logic               haltreq,
    input  logic               ebreak,
    input  logic               retire,
    input  logic               dret,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] next_pc,
    output logic [`DATA_W-1:0] csr_rdata,
    output logic               csr_ack,
    output logic               csr_invalid,
    output logic               halted,
    output priv_level_t        priv,
    output logic               resume,
    output logic [`DATA_W-1:0] resume_pc,
    output logic               breakpoint_trap
);

    // access unit to csr file
    logic               csr_wr;
    logic [1:0]         csr_sel;
    logic [`DATA_W-1:0] csr_wr_data;
    logic [`DATA_W-1:0] csr_rd_data;

    // csr file to entry controller
    logic [`DATA_W-1:0] dpc;
    logic               dcsr_ebreakm;
    logic               dcsr_ebreaku;
    logic               dcsr_step;
    priv_level_t        dcsr_prv;

    // entry controller to csr file
    logic               enter_debug;
    debug_cause_t       enter_cause;
    logic [`DATA_W-1:0] enter_pc;
    priv_level_t        enter_prv;

    csr_access_unit u_access (
        .csr_req     (csr_req),
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .csr_wdata   (csr_wdata),
        .csr_rd_data (csr_rd_data),
        .halted      (halted),
        .csr_ack     (csr_ack),
        .csr_invalid (csr_invalid),
        .csr_rdata   (csr_rdata),
        .csr_wr      (csr_wr),
        .csr_sel     (csr_sel),
        .csr_wr_data (csr_wr_data)
    );

    debug_csr_file u_csrs (
        .CLK          (CLK),
        .nRST         (nRST),
        .csr_wr       (csr_wr),
        .csr_sel      (csr_sel),
        .csr_wr_data  (csr_wr_data),
        .enter_debug  (enter_debug),
        .enter_cause  (enter_cause),
        .enter_pc     (enter_pc),
        .enter_prv    (enter_prv),
        .csr_rd_data  (csr_rd_data),
        .dpc          (dpc),
        .dcsr_ebreakm (dcsr_ebreakm),
        .dcsr_ebreaku (dcsr_ebreaku),
        .dcsr_step    (dcsr_step),
        .dcsr_prv     (dcsr_prv)
    );

    debug_entry_ctrl u_entry (
        .CLK             (CLK),
        .nRST            (nRST),
        .haltreq         (haltreq),
        .ebreak          (ebreak),
        .retire          (retire),
        .dret            (dret),
        .pc              (pc),
        .next_pc         (next_pc),
        .dcsr_ebreakm    (dcsr_ebreakm),
        .dcsr_ebreaku    (dcsr_ebreaku),
        .dcsr_step       (dcsr_step),
        .dcsr_prv        (dcsr_prv),
        .dpc             (dpc),
        .halted          (halted),
        .priv            (priv),
        .resume          (resume),
        .resume_pc       (resume_pc),
        .breakpoint_trap (breakpoint_trap),
        .enter_debug     (enter_debug),
        .enter_cause     (enter_cause),
        .enter_pc        (enter_pc),
        .enter_prv       (enter_prv)
    );

endmodule

`default_nettype wire

//--- include/priv_debug_settings.svh
`ifndef PRIV_DEBUG_SETTINGS_SVH
`define PRIV_DEBUG_SETTINGS_SVH

// csr data path width
`define DATA_W 32

// debug csr addresses
`define CSR_DCSR      12'h7b0
`define CSR_DPC       12'h7b1
`define CSR_DSCRATCH0 12'h7b2
`define CSR_DSCRATCH1 12'h7b3

// dcsr layout, external debug support version 4
`define DCSR_XDEBUGVER   4'd4
`define DCSR_EBREAKM_BIT 15
`define DCSR_EBREAKU_BIT 12
`define DCSR_STEP_BIT    2
`define DCSR_CAUSE_LSB   6
`define DCSR_PRV_LSB     0

`endif

//--- priv_debug_top.f
+incdir+include
hw/priv_debug_pkg.sv
hw/csr_access_unit.sv
hw/debug_csr_file.sv
hw/debug_entry_ctrl.sv
hw/priv_debug_top.sv
sim/priv_debug_assert.sv
sim/priv_debug_tb.sv

//--- sim/priv_debug_assert.sv
`default_nettype none

module priv_debug_assert import priv_debug_pkg::*; (
    input logic        CLK,
    input logic        nRST,
    input logic        csr_req,
    input logic        csr_invalid,
    input logic        halted,
    input logic        dret,
    input logic        resume,
    input priv_level_t dcsr_prv
);

    // number of assertion failures so far
    integer fail_count = 0;

    // only U and M are implemented
    a_prv_legal: assert property (@(posedge CLK) disable iff (!nRST)
        (dcsr_prv == PRIV_U) || (dcsr_prv == PRIV_M))
        else begin
            $error("dcsr.prv holds an unsupported level");
            fail_count++;
        end

    a_resume_after_dret: assert property (@(posedge CLK) disable iff (!nRST)
        resume |-> $past(dret) && $past(halted))
        else begin
            $error("resume without a dret while halted");
            fail_count++;
        end

    a_invalid_running: assert property (@(posedge CLK) disable iff (!nRST)
        (csr_req && !halted) |-> csr_invalid)
        else begin
            $error("csr access while running was not flagged");
            fail_count++;
        end

endmodule

bind priv_debug_top priv_debug_assert u_assert (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .csr_invalid (csr_invalid),
    .halted      (halted),
    .dret        (dret),
    .resume      (resume),
    .dcsr_prv    (dcsr_prv)
);

`default_nettype wire

//--- sim/priv_debug_tb.sv
`default_nettype none
`include "priv_debug_settings.svh"

module priv_debug_tb import priv_debug_pkg::*; ();

    logic               CLK;
    logic               nRST;
    logic               csr_req;
    logic [11:0]        csr_addr;
    csr_op_t            csr_op;
    logic [`DATA_W-1:0] csr_wdata;
    logic               haltreq;
    logic               ebreak;
    logic               retire;
    logic               dret;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] next_pc;
    logic [`DATA_W-1:0] csr_rdata;
    logic               csr_ack;
    logic               csr_invalid;
    logic               halted;
    priv_level_t        priv;
    logic               resume;
    logic [`DATA_W-1:0] resume_pc;
    logic               breakpoint_trap;

    // reference model of the debug state
    logic               m_halted;
    priv_level_t        m_priv;
    logic               m_ebreakm;
    logic               m_ebreaku;
    logic               m_step;
    debug_cause_t       m_cause;
    priv_level_t        m_prv;
    logic [`DATA_W-1:0] m_dpc;
    logic [`DATA_W-1:0] m_scratch0;
    logic [`DATA_W-1:0] m_scratch1;

    integer seed;
    integer errors;
    integer checks;
    integer tests;
    integer test_start;

    priv_debug_top dut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic step_clk();
        @(posedge CLK);
        #1;
    endtask

    function automatic logic [`DATA_W-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic check_word(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_priv(input string name, input priv_level_t got,
                              input priv_level_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // expected dcsr image from the model fields
    function automatic logic [`DATA_W-1:0] model_dcsr();
        logic [`DATA_W-1:0] v;
        v = '0;
        v[`DATA_W-1 -: 4] = 4'd4;
        v[`DCSR_EBREAKM_BIT] = m_ebreakm;
        v[`DCSR_EBREAKU_BIT] = m_ebreaku;
        v[`DCSR_CAUSE_LSB +: 3] = m_cause;
        v[`DCSR_STEP_BIT] = m_step;
        v[`DCSR_PRV_LSB +: 2] = m_prv;
        return v;
    endfunction

    function automatic logic model_hit(input logic [11:0] addr);
        return (addr == `CSR_DCSR) || (addr == `CSR_DPC) ||
               (addr == `CSR_DSCRATCH0) || (addr == `CSR_DSCRATCH1);
    endfunction

    function automatic logic [`DATA_W-1:0] model_read(input logic [11:0] addr);
        case (addr)
            `CSR_DCSR:      return model_dcsr();
            `CSR_DPC:       return m_dpc;
            `CSR_DSCRATCH0: return m_scratch0;
            `CSR_DSCRATCH1: return m_scratch1;
            default:        return '0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [`DATA_W-1:0] v);
        case (addr)
            `CSR_DCSR: begin
                m_ebreakm = v[`DCSR_EBREAKM_BIT];
                m_ebreaku = v[`DCSR_EBREAKU_BIT];
                m_step = v[`DCSR_STEP_BIT];
                // S and reserved leave prv alone
                if (v[`DCSR_PRV_LSB +: 2] == 2'd0 || v[`DCSR_PRV_LSB +: 2] == 2'd3) begin
                    m_prv = priv_level_t'(v[`DCSR_PRV_LSB +: 2]);
                end
            end
            `CSR_DPC:       m_dpc = {v[`DATA_W-1:1], 1'b0};
            `CSR_DSCRATCH0: m_scratch0 = v;
            `CSR_DSCRATCH1: m_scratch1 = v;
            default: ;
        endcase
    endtask

    task automatic model_enter(input debug_cause_t cause, input logic [`DATA_W-1:0] at_pc);
        m_halted = 1'b1;
        m_dpc = {at_pc[`DATA_W-1:1], 1'b0};
        m_cause = cause;
        m_prv = m_priv;
    endtask

    task automatic check_state();
        check_bit("halted", halted, m_halted);
        check_priv("priv", priv, m_priv);
        check_word("resume_pc", resume_pc, m_dpc);
    endtask

    // one request cycle with the response checked mid-cycle
    task automatic csr_access(input csr_op_t op, input logic [11:0] addr,
                              input logic [`DATA_W-1:0] wdata);
        logic               hit;
        logic [`DATA_W-1:0] old;
        logic [`DATA_W-1:0] nv;
        hit = model_hit(addr);
        old = model_read(addr);
        csr_req = 1'b1;
        csr_op = op;
        csr_addr = addr;
        csr_wdata = wdata;
        #1;
        check_bit("csr_ack", csr_ack, hit);
        check_bit("csr_invalid", csr_invalid, !(hit && m_halted));
        check_word("csr_rdata", csr_rdata, old);
        step_clk();
        csr_req = 1'b0;
        case (op)
            CSR_WRITE: nv = wdata;
            CSR_SET:   nv = old | wdata;
            CSR_CLEAR: nv = old & ~wdata;
            default:   nv = old;
        endcase
        if (hit && m_halted && op != CSR_READ) begin
            model_write(addr, nv);
        end
    endtask

    task automatic read_back();
        csr_access(CSR_READ, `CSR_DCSR, '0);
        csr_access(CSR_READ, `CSR_DPC, '0);
    endtask

    task automatic wait_halted(input logic exp, output integer cycles);
        cycles = 0;
        while (halted !== exp && cycles < 20) begin
            step_clk();
            cycles++;
        end
        if (halted !== exp) begin
            errors++;
            $display("timeout: halted did not become %0b within 20 cycles", exp);
        end
    endtask

    task automatic wait_resume(output integer cycles);
        cycles = 0;
        while (resume !== 1'b1 && cycles < 20) begin
            step_clk();
            cycles++;
        end
        if (resume !== 1'b1) begin
            errors++;
            $display("timeout: no resume pulse within 20 cycles");
        end
    endtask

    task automatic halt_by_request(input logic [`DATA_W-1:0] at_pc);
        integer n;
        pc = at_pc;
        haltreq = 1'b1;
        step_clk();
        haltreq = 1'b0;
        wait_halted(1'b1, n);
        check_word("halt delay", n, 0);
        model_enter(CAUSE_HALTREQ, at_pc);
        check_state();
    endtask

    task automatic resume_by_dret();
        integer n;
        dret = 1'b1;
        step_clk();
        dret = 1'b0;
        wait_resume(n);
        check_word("resume delay", n, 0);
        m_halted = 1'b0;
        m_priv = m_prv;
        check_state();
        step_clk();
        check_bit("resume", resume, 1'b0);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        logic [`DATA_W-1:0] r;
        logic [`DATA_W-1:0] at_pc;
        logic [`DATA_W-1:0] at_next;
        logic [11:0]        a;
        integer             k;
        integer             n;
        seed = 60;
        errors = 0;
        checks = 0;
        tests = 0;
        test_start = 0;
        nRST = 1'b0;
        csr_req = 1'b0;
        csr_addr = '0;
        csr_op = CSR_READ;
        csr_wdata = '0;
        haltreq = 1'b0;
        ebreak = 1'b0;
        retire = 1'b0;
        dret = 1'b0;
        pc = '0;
        next_pc = '0;
        m_halted = 1'b0;
        m_priv = PRIV_M;
        m_ebreakm = 1'b0;
        m_ebreaku = 1'b0;
        m_step = 1'b0;
        m_cause = CAUSE_NONE;
        m_prv = PRIV_M;
        m_dpc = '0;
        m_scratch0 = '0;
        m_scratch1 = '0;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        check_state();
        check_bit("resume", resume, 1'b0);
        check_bit("breakpoint_trap", breakpoint_trap, 1'b0);
        // hart is running and both accesses must bounce
        csr_access(CSR_WRITE, `CSR_DSCRATCH0, rand_word());
        csr_access(CSR_SET, `CSR_DCSR, rand_word());
        finish_test("reset values");

        halt_by_request(rand_word());
        read_back();
        csr_access(CSR_READ, `CSR_DSCRATCH0, '0);
        finish_test("halt request entry");

        for (int i = 0; i < 40; i++) begin
            k = rand_word() % 5;
            r = rand_word();
            case (k)
                0: a = `CSR_DCSR;
                1: a = `CSR_DPC;
                2: a = `CSR_DSCRATCH0;
                3: a = `CSR_DSCRATCH1;
                default: begin
                    a = r[11:0];
                    // keep clear of the debug block
                    if (a[11:2] == 10'h1ec) begin
                        a = a ^ 12'h100;
                    end
                end
            endcase
            csr_access(csr_op_t'(r[13:12]), a, rand_word());
        end
        csr_access(CSR_WRITE, `CSR_DCSR, 32'h0000_01c1);
        csr_access(CSR_WRITE, `CSR_DCSR, 32'h0000_0002);
        csr_access(CSR_READ, `CSR_DCSR, '0);
        finish_test("csr read-modify-write");

        csr_access(CSR_WRITE, `CSR_DPC, rand_word());
        csr_access(CSR_WRITE, `CSR_DCSR, '0);
        resume_by_dret();
        check_priv("priv", priv, PRIV_U);
        finish_test("dret resume");

        pc = rand_word();
        ebreak = 1'b1;
        #1;
        check_bit("breakpoint_trap", breakpoint_trap, 1'b1);
        step_clk();
        ebreak = 1'b0;
        check_state();
        step_clk();
        check_bit("breakpoint_trap", breakpoint_trap, 1'b0);
        halt_by_request(rand_word());
        csr_access(CSR_WRITE, `CSR_DCSR, 1 << `DCSR_EBREAKU_BIT);
        resume_by_dret();
        at_pc = rand_word();
        pc = at_pc;
        ebreak = 1'b1;
        #1;
        check_bit("breakpoint_trap", breakpoint_trap, 1'b0);
        step_clk();
        ebreak = 1'b0;
        wait_halted(1'b1, n);
        check_word("halt delay", n, 0);
        model_enter(CAUSE_EBREAK, at_pc);
        check_state();
        read_back();
        finish_test("ebreak gating");

        csr_access(CSR_WRITE, `CSR_DCSR, (1 << `DCSR_STEP_BIT) | 3);
        resume_by_dret();
        at_pc = rand_word();
        at_next = rand_word();
        pc = at_pc;
        next_pc = at_next;
        retire = 1'b1;
        step_clk();
        retire = 1'b0;
        wait_halted(1'b1, n);
        check_word("halt delay", n, 0);
        model_enter(CAUSE_STEP, at_next);
        check_state();
        read_back();
        // haltreq wins over a step in the same cycle
        resume_by_dret();
        at_pc = rand_word();
        pc = at_pc;
        next_pc = rand_word();
        haltreq = 1'b1;
        retire = 1'b1;
        step_clk();
        haltreq = 1'b0;
        retire = 1'b0;
        wait_halted(1'b1, n);
        check_word("halt delay", n, 0);
        model_enter(CAUSE_HALTREQ, at_pc);
        check_state();
        read_back();
        finish_test("single step");

        if (dut.u_assert.fail_count != 0) begin
            $display("bound checker saw %0d assertion failures", dut.u_assert.fail_count);
            errors += dut.u_assert.fail_count;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
